// File: include/parking_macros.svh
// Width, count, fee rate and plate prefix constants for the parking tower

`ifndef PARKING_MACROS_SVH
`define PARKING_MACROS_SVH

// Plate and floor widths
`define PLATE_W 16
`define FLOOR_W 3

// Seven parking floors above ground floor 0
`define NUM_FLOORS 7

// Pending order slots
`define QUEUE_DEPTH 8

// Fee counter width and rates per occupied edge
`define FEE_W 8
`define RATE_STD 2
`define RATE_HYBRID 1

// Top nibble of the plate
`define PREFIX_DISABLED 9
`define PREFIX_HYBRID 8

`endif

// File: verilog/parking_pkg.sv
// Plate, floor and place types, car classes and the lot record struct
`default_nettype none

`include "parking_macros.svh"

package parking_pkg;

	// Zero plate marks an empty place
	typedef logic [`PLATE_W-1:0] plate_t;

	typedef logic [`FLOOR_W-1:0] floor_t;

	typedef logic [`FEE_W-1:0] fee_t;

	typedef enum logic {
		SIDE_LEFT = 1'b0,
		SIDE_RIGHT = 1'b1
	} side_e;

	typedef struct packed {
		floor_t floor;
		side_e side;
	} place_t;

	// One left and one right plate per floor, floors 1 to 7
	typedef struct packed {
		plate_t [`NUM_FLOORS:1] left;
		plate_t [`NUM_FLOORS:1] right;
	} lot_t;

	typedef enum logic {
		CAR_SEDAN = 1'b0,
		CAR_SUV = 1'b1
	} car_class_e;

	// Odd plates are SUVs
	function automatic car_class_e car_class(plate_t p);
		return p[0] ? CAR_SUV : CAR_SEDAN;
	endfunction

endpackage

`default_nettype wire

// File: verilog/elevator_pkg.sv
// Order kinds, the queued order struct and elevator FSM states
`default_nettype none

package elevator_pkg;
	import parking_pkg::*;

	typedef enum logic {
		ORDER_PARK = 1'b0,
		ORDER_RETRIEVE = 1'b1
	} order_e;

	typedef struct packed {
		logic valid;
		order_e kind;
		plate_t plate;
	} order_t;

	typedef enum logic [2:0] {
		LIFT_IDLE,
		LIFT_LOAD,
		LIFT_RISE,
		LIFT_STORE,
		LIFT_FETCH,
		LIFT_DESCEND,
		LIFT_UNLOAD
	} lift_state_e;

endpackage

`default_nettype wire

// File: verilog/order_queue.sv
// Circular queue of pending park and retrieve orders
`timescale 1ns/10ps
`default_nettype none

`include "parking_macros.svh"

module order_queue import parking_pkg::*, elevator_pkg::*; (
	input wire clock,
	input wire reset,
	input wire park_req,
	input wire retrieve_req,
	input wire plate_t plate,
	input wire order_take,
	output order_t head,
	output logic queue_full
);

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(`QUEUE_DEPTH);

	order_e kind_mem [`QUEUE_DEPTH];
	plate_t plate_mem [`QUEUE_DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;
	order_e push_kind;

	assign queue_full = (count == FULL_COUNT);

	// Park wins when both strobes arrive together
	assign push_kind = park_req ? ORDER_PARK : ORDER_RETRIEVE;
	assign push = (park_req || retrieve_req) && !queue_full;
	assign pop = order_take && head.valid;

	always_ff @(posedge clock) begin
		if (push) begin
			kind_mem[wr_ptr] <= push_kind;
			plate_mem[wr_ptr] <= plate;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Oldest entry, valid whenever something is waiting
	always_comb begin
		head.valid = (count != '0);
		head.kind = kind_mem[rd_ptr];
		head.plate = plate_mem[rd_ptr];
	end

endmodule

`default_nettype wire

// File: verilog/target_floor.sv
// Place selection for the head order, free place for parking or the car's place
`timescale 1ns/10ps
`default_nettype none

`include "parking_macros.svh"

module target_floor import parking_pkg::*, elevator_pkg::*; (
	input wire order_t head,
	input wire lot_t lot,
	output place_t target,
	output logic target_ok
);

	car_class_e car;
	logic evens_full;
	logic [`NUM_FLOORS:1] allowed;
	logic park_hit;
	place_t park_place;
	logic find_hit;
	place_t find_place;

	assign car = car_class(head.plate);

	// Floors this car may use
	always_comb begin
		evens_full = 1'b1;
		for (int f = 2; f <= `NUM_FLOORS; f += 2) begin
			if (lot.left[f] == '0 || lot.right[f] == '0) begin
				evens_full = 1'b0;
			end
		end
		for (int f = 1; f <= `NUM_FLOORS; f++) begin
			if (f % 2 == 0) begin
				allowed[f] = (car == CAR_SEDAN);
			end else begin
				// Sedans spill over once the even floors are full
				allowed[f] = (car == CAR_SUV) || evens_full;
			end
		end
	end

	// Lowest allowed floor with room, right place preferred
	always_comb begin
		park_hit = 1'b0;
		park_place = '0;
		for (int f = 1; f <= `NUM_FLOORS; f++) begin
			if (!park_hit && allowed[f] && (lot.right[f] == '0 || lot.left[f] == '0)) begin
				park_hit = 1'b1;
				park_place.floor = floor_t'(f);
				park_place.side = (lot.right[f] == '0) ? SIDE_RIGHT : SIDE_LEFT;
			end
		end
	end

	// Search upward, left before right
	always_comb begin
		find_hit = 1'b0;
		find_place = '0;
		for (int f = 1; f <= `NUM_FLOORS; f++) begin
			if (!find_hit && lot.left[f] == head.plate) begin
				find_hit = 1'b1;
				find_place.floor = floor_t'(f);
				find_place.side = SIDE_LEFT;
			end else if (!find_hit && lot.right[f] == head.plate) begin
				find_hit = 1'b1;
				find_place.floor = floor_t'(f);
				find_place.side = SIDE_RIGHT;
			end
		end
	end

	assign target = (head.kind == ORDER_PARK) ? park_place : find_place;

	// A zero plate would match an empty place
	assign target_ok = head.valid && (head.plate != '0) &&
		((head.kind == ORDER_PARK) ? park_hit : find_hit);

endmodule

`default_nettype wire

// File: verilog/elevator_controller.sv
// Elevator FSM with floor counter, cab register and the place records
`timescale 1ns/10ps
`default_nettype none

module elevator_controller import parking_pkg::*, elevator_pkg::*; (
	input wire clock,
	input wire reset,
	input wire order_t head,
	input wire place_t target,
	input wire target_ok,
	output logic order_take,
	output logic order_reject,
	output lot_t lot,
	output plate_t cab,
	output floor_t current_floor,
	output logic lift_strobe,
	output place_t lift_place
);

	lift_state_e state;
	order_e kind_q;
	place_t dest;
	plate_t load_plate;

	// Orders start only from the ground floor
	assign order_take = (state == LIFT_IDLE) && head.valid && (current_floor == '0);

	// Car leaves its place at the end of the fetch cycle
	assign lift_strobe = (state == LIFT_FETCH);
	assign lift_place = dest;

	always_ff @(posedge clock) begin
		if (order_take) begin
			dest <= target;
			load_plate <= head.plate;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= LIFT_IDLE;
			kind_q <= ORDER_PARK;
			current_floor <= '0;
			cab <= '0;
			lot <= '0;
			order_reject <= 1'b0;
		end else begin
			order_reject <= 1'b0;
			case (state)
				LIFT_IDLE: begin
					if (order_take) begin
						kind_q <= head.kind;
						if (!target_ok) begin
							order_reject <= 1'b1;
						end else if (head.kind == ORDER_PARK) begin
							state <= LIFT_LOAD;
						end else begin
							state <= LIFT_RISE;
						end
					end
				end
				LIFT_LOAD: begin
					cab <= load_plate;
					state <= LIFT_RISE;
				end
				LIFT_RISE: begin
					current_floor <= current_floor + 1'b1;
					if (current_floor + 1'b1 == dest.floor) begin
						state <= (kind_q == ORDER_PARK) ? LIFT_STORE : LIFT_FETCH;
					end
				end
				LIFT_STORE: begin
					if (dest.side == SIDE_LEFT) begin
						lot.left[dest.floor] <= cab;
					end else begin
						lot.right[dest.floor] <= cab;
					end
					cab <= '0;
					state <= LIFT_DESCEND;
				end
				LIFT_FETCH: begin
					if (dest.side == SIDE_LEFT) begin
						cab <= lot.left[dest.floor];
						lot.left[dest.floor] <= '0;
					end else begin
						cab <= lot.right[dest.floor];
						lot.right[dest.floor] <= '0;
					end
					state <= LIFT_DESCEND;
				end
				LIFT_DESCEND: begin
					current_floor <= current_floor - 1'b1;
					// Retrieved car still has to be driven off
					if (current_floor == floor_t'(1)) begin
						state <= (kind_q == ORDER_PARK) ? LIFT_IDLE : LIFT_UNLOAD;
					end
				end
				LIFT_UNLOAD: begin
					cab <= '0;
					state <= LIFT_IDLE;
				end
				default: begin
					state <= LIFT_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/fee_bank.sv
// Per-place fee counters and the fee report when a car is lifted out
`timescale 1ns/10ps
`default_nettype none

`include "parking_macros.svh"

module fee_bank import parking_pkg::*; (
	input wire clock,
	input wire reset,
	input wire lot_t lot,
	input wire lift_strobe,
	input wire place_t lift_place,
	output fee_t fee,
	output logic fee_valid
);

	fee_t left_count [1:`NUM_FLOORS];
	fee_t right_count [1:`NUM_FLOORS];

	function automatic fee_t rate_of(plate_t p);
		if (p[`PLATE_W-1 -: 4] == 4'(`PREFIX_DISABLED)) begin
			return '0;
		end
		if (p[`PLATE_W-1 -: 4] == 4'(`PREFIX_HYBRID)) begin
			return fee_t'(`RATE_HYBRID);
		end
		return fee_t'(`RATE_STD);
	endfunction

	// Saturating step, empty place restarts at zero
	function automatic fee_t next_count(fee_t c, plate_t p);
		logic [`FEE_W:0] sum;
		if (p == '0) begin
			return '0;
		end
		sum = {1'b0, c} + {1'b0, rate_of(p)};
		return sum[`FEE_W] ? '1 : sum[`FEE_W-1:0];
	endfunction

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int f = 1; f <= `NUM_FLOORS; f++) begin
				left_count[f] <= '0;
				right_count[f] <= '0;
			end
			fee_valid <= 1'b0;
		end else begin
			for (int f = 1; f <= `NUM_FLOORS; f++) begin
				left_count[f] <= next_count(left_count[f], lot.left[f]);
				right_count[f] <= next_count(right_count[f], lot.right[f]);
			end
			fee_valid <= lift_strobe;
		end
	end

	// Includes the increment of the lift edge itself
	always_ff @(posedge clock) begin
		if (lift_strobe) begin
			if (lift_place.side == SIDE_LEFT) begin
				fee <= next_count(left_count[lift_place.floor], lot.left[lift_place.floor]);
			end else begin
				fee <= next_count(right_count[lift_place.floor], lot.right[lift_place.floor]);
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/parking_lot_top.sv
// Parking tower top level joining queue, target selection, elevator and fees
`timescale 1ns/10ps
`default_nettype none

module parking_lot_top import parking_pkg::*, elevator_pkg::*; (
	input wire clock,
	input wire reset,
	input wire park_req,
	input wire retrieve_req,
	input wire plate_t plate,
	output lot_t lot,
	output floor_t current_floor,
	output plate_t cab,
	output logic queue_full,
	output logic order_reject,
	output fee_t fee,
	output logic fee_valid
);

	order_t head;
	logic order_take;
	place_t target;
	logic target_ok;
	logic lift_strobe;
	place_t lift_place;

	order_queue order_queue_i (
		.clock(clock),
		.reset(reset),
		.park_req(park_req),
		.retrieve_req(retrieve_req),
		.plate(plate),
		.order_take(order_take),
		.head(head),
		.queue_full(queue_full)
	);

	target_floor target_floor_i (
		.head(head),
		.lot(lot),
		.target(target),
		.target_ok(target_ok)
	);

	elevator_controller elevator_controller_i (
		.clock(clock),
		.reset(reset),
		.head(head),
		.target(target),
		.target_ok(target_ok),
		.order_take(order_take),
		.order_reject(order_reject),
		.lot(lot),
		.cab(cab),
		.current_floor(current_floor),
		.lift_strobe(lift_strobe),
		.lift_place(lift_place)
	);

	// Meters every occupied place
	fee_bank fee_bank_i (
		.clock(clock),
		.reset(reset),
		.lot(lot),
		.lift_strobe(lift_strobe),
		.lift_place(lift_place),
		.fee(fee),
		.fee_valid(fee_valid)
	);

endmodule

`default_nettype wire

// File: tb/tb_parking_lot.sv
// Parking tower testbench with stimulus, a reference model of queue,
// placement and fees, assertions and a cycle timeout
`timescale 1ns/10ps
`default_nettype none

`include "parking_macros.svh"

module tb_parking_lot import parking_pkg::*, elevator_pkg::*; ();

	localparam int MAX_CYCLES = 1500;

	logic clock;
	logic reset;
	logic park_req;
	logic retrieve_req;
	plate_t plate;
	lot_t lot;
	floor_t current_floor;
	plate_t cab;
	logic queue_full;
	logic order_reject;
	fee_t fee;
	logic fee_valid;

	// Reference model state
	order_e q_kind[$];
	plate_t q_plate[$];
	lot_t ref_lot;
	lot_t prev_lot;
	int edges_left [1:`NUM_FLOORS];
	int edges_right [1:`NUM_FLOORS];
	logic pending;
	order_e pend_kind;
	place_t pend_place;
	plate_t pend_plate;
	logic fee_seen;
	int deadline;
	logic reject_due;
	logic prev_lift;
	floor_t prev_floor;
	logic saw_full;
	int cyc;
	int error_count;
	int idx;
	integer seed;

	parking_lot_top dut_i (
		.clock(clock),
		.reset(reset),
		.park_req(park_req),
		.retrieve_req(retrieve_req),
		.plate(plate),
		.lot(lot),
		.current_floor(current_floor),
		.cab(cab),
		.queue_full(queue_full),
		.order_reject(order_reject),
		.fee(fee),
		.fee_valid(fee_valid)
	);

	always #20 clock = ~clock;

	task automatic report_mismatch(input string name, input int exp, input int act);
		error_count++;
		$display("FAIL %s expected %0h actual %0h", name, exp, act);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic lot_mismatch(input string name, input lot_t exp, input lot_t act);
		error_count++;
		$display("FAIL %s expected %h actual %h", name, exp, act);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		error_count++;
		$display("%s", what);
		$display("test failed");
		$fatal(1);
	endtask

	// Rejects only come while the cab waits at ground level
	assert property (@(posedge clock) disable iff (!reset) order_reject |-> current_floor == '0)
		else report_mismatch("reject_floor", 0, int'(current_floor));

	function automatic int plate_rate(plate_t p);
		if (p[15:12] == 4'(`PREFIX_DISABLED)) begin
			return 0;
		end
		if (p[15:12] == 4'(`PREFIX_HYBRID)) begin
			return 1;
		end
		return 2;
	endfunction

	function automatic lot_t with_slot(lot_t l, place_t pl, plate_t p);
		lot_t r;
		r = l;
		if (pl.side == SIDE_LEFT) begin
			r.left[pl.floor] = p;
		end else begin
			r.right[pl.floor] = p;
		end
		return r;
	endfunction

	// SUVs on odd floors and sedans on even ones until those fill up
	task automatic choose_park(input lot_t l, input plate_t p, output place_t pl, output logic ok);
		logic sedan;
		logic evens_full;
		logic may;
		sedan = !p[0];
		evens_full = 1'b1;
		ok = 1'b0;
		pl = '0;
		for (int f = 2; f <= `NUM_FLOORS; f += 2) begin
			if (l.left[f] == '0 || l.right[f] == '0) begin
				evens_full = 1'b0;
			end
		end
		for (int f = 1; f <= `NUM_FLOORS; f++) begin
			may = (f % 2 == 0) ? sedan : (!sedan || evens_full);
			if (!ok && may && l.right[f] == '0) begin
				ok = 1'b1;
				pl.floor = floor_t'(f);
				pl.side = SIDE_RIGHT;
			end else if (!ok && may && l.left[f] == '0) begin
				ok = 1'b1;
				pl.floor = floor_t'(f);
				pl.side = SIDE_LEFT;
			end
		end
	endtask

	task automatic find_car(input lot_t l, input plate_t p, output place_t pl, output logic ok);
		ok = 1'b0;
		pl = '0;
		for (int f = 1; f <= `NUM_FLOORS; f++) begin
			if (!ok && l.left[f] == p) begin
				ok = 1'b1;
				pl.floor = floor_t'(f);
				pl.side = SIDE_LEFT;
			end else if (!ok && l.right[f] == p) begin
				ok = 1'b1;
				pl.floor = floor_t'(f);
				pl.side = SIDE_RIGHT;
			end
		end
	endtask

	// Start of an order taken by the elevator
	task automatic serve(input order_e kind, input plate_t p);
		place_t pl;
		logic ok;
		if (kind == ORDER_PARK) begin
			choose_park(ref_lot, p, pl, ok);
		end else begin
			find_car(ref_lot, p, pl, ok);
		end
		if (!ok) begin
			reject_due = 1'b1;
		end else begin
			ref_lot = with_slot(ref_lot, pl, (kind == ORDER_PARK) ? p : '0);
			pending = 1'b1;
			pend_kind = kind;
			pend_place = pl;
			pend_plate = p;
			fee_seen = 1'b0;
			deadline = cyc + 2 * int'(pl.floor) + 3;
		end
	endtask

	// Monitor samples at the falling edge where outputs are settled
	always @(negedge clock) begin
		int d;
		int exp_fee;
		logic full_before;
		if (!reset) begin
			prev_lot = '0;
			prev_floor = '0;
			prev_lift = 1'b0;
		end else begin
			cyc++;
			if (cyc > MAX_CYCLES) begin
				report_error("timeout, the orders did not complete in time");
			end
			for (int f = 1; f <= `NUM_FLOORS; f++) begin
				edges_left[f] = (prev_lot.left[f] != '0) ? edges_left[f] + 1 : 0;
				edges_right[f] = (prev_lot.right[f] != '0) ? edges_right[f] + 1 : 0;
			end
			d = int'(current_floor) - int'(prev_floor);
			assert (d <= 1 && d >= -1)
				else report_mismatch("floor_step", int'(prev_floor), int'(current_floor));
			assert (order_reject == reject_due)
				else report_mismatch("order_reject", int'(reject_due), int'(order_reject));
			reject_due = 1'b0;
			assert (fee_valid == prev_lift)
				else report_mismatch("fee_valid", int'(prev_lift), int'(fee_valid));
			if (fee_valid) begin
				assert (pending && pend_kind == ORDER_RETRIEVE)
					else report_error("fee reported without a retrieve in flight");
				assert (cab == pend_plate)
					else report_mismatch("fetch_cab", int'(pend_plate), int'(cab));
				exp_fee = plate_rate(pend_plate) *
					((pend_place.side == SIDE_LEFT) ? edges_left[pend_place.floor] :
					edges_right[pend_place.floor]);
				if (exp_fee > 255) begin
					exp_fee = 255;
				end
				assert (int'(fee) == exp_fee)
					else report_mismatch("fee", exp_fee, int'(fee));
				fee_seen = 1'b1;
			end
			if (pending && cyc == deadline) begin
				assert (current_floor == '0)
					else report_mismatch("latency_floor", 0, int'(current_floor));
				assert (cab == '0)
					else report_mismatch("latency_cab", 0, int'(cab));
				assert (lot == ref_lot)
					else lot_mismatch("lot_record", ref_lot, lot);
				assert (pend_kind == ORDER_PARK || fee_seen)
					else report_error("no fee was reported for the retrieved car");
				pending = 1'b0;
			end
			full_before = (q_kind.size() == `QUEUE_DEPTH);
			assert (queue_full == full_before)
				else report_mismatch("queue_full", int'(full_before), int'(queue_full));
			if (queue_full) begin
				saw_full = 1'b1;
			end
			if (dut_i.order_take) begin
				assert (!pending && q_kind.size() > 0)
					else report_error("order taken while busy or with an empty queue");
				serve(q_kind.pop_front(), q_plate.pop_front());
			end
			if ((park_req || retrieve_req) && !full_before) begin
				q_kind.push_back(park_req ? ORDER_PARK : ORDER_RETRIEVE);
				q_plate.push_back(plate);
			end
			prev_lot = lot;
			prev_floor = current_floor;
			prev_lift = dut_i.lift_strobe;
		end
	end

	function automatic plate_t make_plate(input logic [3:0] nib, input logic cls);
		integer r;
		r = $random(seed);
		idx++;
		return plate_t'({nib, idx[7:0], r[2:0], cls});
	endfunction

	task automatic send(input order_e kind, input plate_t p);
		@(posedge clock);
		#2;
		park_req = (kind == ORDER_PARK);
		retrieve_req = (kind == ORDER_RETRIEVE);
		plate = p;
		@(posedge clock);
		#2;
		park_req = 1'b0;
		retrieve_req = 1'b0;
	endtask

	task automatic wait_idle();
		@(posedge clock);
		while (q_kind.size() != 0 || pending || reject_due) begin
			@(posedge clock);
		end
	endtask

	task automatic run_order(input order_e kind, input plate_t p);
		send(kind, p);
		wait_idle();
	endtask

	initial begin
		plate_t sedans [0:7];
		plate_t suvs [0:6];
		clock = 1'b0;
		reset = 1'b0;
		park_req = 1'b0;
		retrieve_req = 1'b0;
		plate = '0;
		seed = 4;
		idx = 0;
		cyc = 0;
		error_count = 0;
		pending = 1'b0;
		fee_seen = 1'b0;
		reject_due = 1'b0;
		saw_full = 1'b0;
		ref_lot = '0;
		for (int f = 1; f <= `NUM_FLOORS; f++) begin
			edges_left[f] = 0;
			edges_right[f] = 0;
		end
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b1;
		assert (current_floor == '0)
			else report_mismatch("reset_floor", 0, int'(current_floor));
		assert (cab == '0)
			else report_mismatch("reset_cab", 0, int'(cab));
		assert (lot == '0)
			else lot_mismatch("reset_lot", '0, lot);
		assert (!queue_full && !order_reject && !fee_valid)
			else report_mismatch("reset_status", 0, int'({queue_full, order_reject, fee_valid}));

		// Fill the even floors with sedans starting with disabled and hybrid plates
		sedans[0] = make_plate(4'h9, 1'b0);
		sedans[1] = make_plate(4'h8, 1'b0);
		for (int i = 2; i < 8; i++) begin
			sedans[i] = make_plate(4'h1, 1'b0);
		end
		for (int i = 0; i < 7; i++) begin
			suvs[i] = make_plate(4'h2, 1'b1);
		end
		for (int i = 0; i < 6; i++) begin
			run_order(ORDER_PARK, sedans[i]);
		end
		run_order(ORDER_PARK, suvs[0]);
		// Evens are full so this sedan spills onto floor 1
		run_order(ORDER_PARK, sedans[6]);
		for (int i = 1; i < 7; i++) begin
			run_order(ORDER_PARK, suvs[i]);
		end
		run_order(ORDER_PARK, sedans[7]);
		run_order(ORDER_RETRIEVE, make_plate(4'h3, 1'b0));

		run_order(ORDER_RETRIEVE, sedans[0]);
		run_order(ORDER_RETRIEVE, sedans[1]);
		sedans[0] = make_plate(4'h1, 1'b0);
		run_order(ORDER_PARK, sedans[0]);
		repeat (5) @(posedge clock);
		run_order(ORDER_RETRIEVE, sedans[0]);
		repeat (150) @(posedge clock);
		run_order(ORDER_RETRIEVE, sedans[2]);

		// Burst of ten strobes behind a long retrieve from floor 7
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			#2;
			park_req = (i == 4 || i == 7);
			retrieve_req = !(i == 4 || i == 7);
			plate = (i == 0) ? suvs[6] : (park_req ? make_plate(4'h8, 1'b0) :
				((i % 2 == 0) ? suvs[i / 2] : sedans[3 + i / 3]));
		end
		@(posedge clock);
		#2;
		park_req = 1'b0;
		retrieve_req = 1'b0;
		wait_idle();
		assert (saw_full)
			else report_error("queue_full never rose during the burst");
		repeat (4) @(posedge clock);

		if (error_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: parking_lot.f
+incdir+include
verilog/parking_pkg.sv
verilog/elevator_pkg.sv
verilog/order_queue.sv
verilog/target_floor.sv
verilog/elevator_controller.sv
verilog/fee_bank.sv
verilog/parking_lot_top.sv
tb/tb_parking_lot.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the parking tower testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f parking_lot.f \
	--top-module tb_parking_lot \
	--Mdir obj_dir -o tb_parking_lot

./obj_dir/tb_parking_lot
